// File: sim.f
+incdir+verilog
verilog/pet_bus_pkg.sv
verilog/cpu_bus_if.sv
verilog/address_decoding.sv
verilog/io_register_bank.sv
verilog/ram_port.sv
verilog/read_data_mux.sv
verilog/pet_bus_top.sv
verif/pet_bus_props.sv
verif/pet_bus_tb.sv

// File: Makefile
# Verilator build and run of the PET bus testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module pet_bus_tb -f sim.f -o Vpet_bus_tb
	./obj_dir/Vpet_bus_tb > sim.log 2>&1 || echo "*** FAILED ***" >> sim.log
	@cat sim.log
	@if grep -qF '*** FAILED ***' sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: verif/pet_bus_tb.sv
`timescale 1ns/1ps
`include "pet_bus_defs.svh"

module pet_bus_tb;
    localparam int NUM_ROWS   = 40;
    localparam int WAIT_LIMIT = 200;                    // Edges a request may wait
    localparam int RSP_LIMIT  = 2000;                   // Edges for one pass to drain
    localparam logic WR    = 1'b1;
    localparam logic RD    = 1'b0;
    localparam logic BE    = 1'b1;
    localparam logic NO_BE = 1'b0;

    typedef struct packed {
        logic                       be;
        logic [`CPU_ADDR_WIDTH-1:0] addr;
        logic                       we;
        logic [`CPU_DATA_WIDTH-1:0] wdata;
    } access_t;

    logic                       clk_i;
    logic                       arst_n_i;
    logic                       cpu_valid_i;
    logic                       cpu_ready_o;
    logic                       cpu_be_i;
    logic [`CPU_ADDR_WIDTH-1:0] cpu_addr_i;
    logic                       cpu_we_i;
    logic [`CPU_DATA_WIDTH-1:0] cpu_wdata_i;
    logic                       rsp_valid_o;
    logic                       rsp_ready_i;
    logic [`CPU_DATA_WIDTH-1:0] rsp_data_o;

    logic [`CPU_DATA_WIDTH-1:0] ref_mem [2 ** `CPU_ADDR_WIDTH];
    logic [`CPU_DATA_WIDTH-1:0] ref_regs [`NUM_IO_BANKS][2 ** `IO_REG_ADDR_BITS];
    logic [`CPU_DATA_WIDTH-1:0] exp_q [$];
    int                         acc_edge_q [$];
    int                         edge_cnt = 0;

    access_t acc_table [NUM_ROWS] = '{
        '{BE, 16'h0000, WR, 8'h11}, '{BE, 16'h7FFF, WR, 8'h22},   // Main RAM
        '{BE, 16'h1234, WR, 8'h33}, '{BE, 16'h0000, RD, 8'h00},
        '{BE, 16'h7FFF, RD, 8'h00}, '{BE, 16'h1234, RD, 8'h00},
        '{BE, 16'h9000, WR, 8'h44}, '{BE, 16'h9000, RD, 8'h00},   // ROM ignores writes
        '{BE, 16'hE7FF, WR, 8'h45}, '{BE, 16'hE7FF, RD, 8'h00},
        '{BE, 16'hE900, WR, 8'h46}, '{BE, 16'hE900, RD, 8'h00},
        '{BE, 16'hFFFF, WR, 8'h47}, '{BE, 16'hFFFF, RD, 8'h00},
        '{BE, 16'h8000, WR, 8'h5A}, '{BE, 16'h8400, RD, 8'h00},   // VRAM mirrors
        '{BE, 16'h8800, RD, 8'h00}, '{BE, 16'h8C00, RD, 8'h00},
        '{BE, 16'h8F00, WR, 8'h6B}, '{BE, 16'h8F00, RD, 8'h00},   // SID over VRAM
        '{BE, 16'h8000, RD, 8'h00}, '{BE, 16'h8F01, WR, 8'hA1},
        '{BE, 16'hE801, WR, 8'hB2}, '{BE, 16'hE811, WR, 8'hC3},   // One reg per bank
        '{BE, 16'hE821, WR, 8'hD4}, '{BE, 16'hE841, WR, 8'hE5},
        '{BE, 16'hE881, WR, 8'hF6}, '{BE, 16'h8FF1, RD, 8'h00},   // Window aliases
        '{BE, 16'hE801, RD, 8'h00}, '{BE, 16'hE811, RD, 8'h00},
        '{BE, 16'hE831, RD, 8'h00}, '{BE, 16'hE871, RD, 8'h00},
        '{BE, 16'hE8F1, RD, 8'h00}, '{BE, 16'hE802, RD, 8'h00},
        '{BE, 16'h8C05, WR, 8'h77}, '{BE, 16'h8005, RD, 8'h00},
        '{NO_BE, 16'h0000, WR, 8'h99}, '{NO_BE, 16'h0000, RD, 8'h00},  // Bus not enabled
        '{NO_BE, 16'hE801, RD, 8'h00}, '{BE, 16'h0000, RD, 8'h00}
    };

    pet_bus_top dut_i (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .cpu_valid_i (cpu_valid_i),
        .cpu_ready_o (cpu_ready_o),
        .cpu_be_i    (cpu_be_i),
        .cpu_addr_i  (cpu_addr_i),
        .cpu_we_i    (cpu_we_i),
        .cpu_wdata_i (cpu_wdata_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_data_o  (rsp_data_o)
    );

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        edge_cnt <= edge_cnt + 1;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on first error");
    endtask

    // PET map model updated in acceptance order
    function automatic logic [`CPU_DATA_WIDTH-1:0] predict(input access_t acc,
                                                           input logic [7:0] wdata);
        logic [`CPU_ADDR_WIDTH-1:0] a;
        logic [2:0]                 bank;
        logic                       bank_hit;
        a        = acc.addr;
        bank     = 3'd0;
        bank_hit = 1'b1;
        if (!acc.be) begin
            return acc.we ? 8'h00 : 8'hFF;              // Open bus on reads
        end
        if (a >= 16'h8F00 && a <= 16'h8FFF) begin
            bank = 3'd0;                                // SID
        end else if (a >= 16'hE800 && a <= 16'hE80F) begin
            bank = 3'd1;                                // MAGIC
        end else if (a >= 16'hE810 && a <= 16'hE81F) begin
            bank = 3'd2;                                // PIA1
        end else if (a >= 16'hE820 && a <= 16'hE83F) begin
            bank = 3'd3;                                // PIA2
        end else if (a >= 16'hE840 && a <= 16'hE87F) begin
            bank = 3'd4;                                // VIA
        end else if (a >= 16'hE880 && a <= 16'hE8FF) begin
            bank = 3'd5;                                // CRTC
        end else begin
            bank_hit = 1'b0;
        end
        if (bank_hit) begin
            if (acc.we) begin
                ref_regs[bank][a[3:0]] = wdata;
                return 8'h00;
            end
            return ref_regs[bank][a[3:0]];
        end
        if (a >= 16'h8000 && a <= 16'h8FFF) begin
            a[11:10] = 2'b00;                           // 1 KB VRAM seen four times
        end
        if (acc.we) begin
            if (a < 16'h9000) begin
                ref_mem[a] = wdata;                     // ROM above keeps its contents
            end
            return 8'h00;
        end
        return ref_mem[a];
    endfunction

    task automatic send_request(input access_t acc, input int pass_idx);
        int          waited;
        logic [7:0] wdata;
        wdata       = (pass_idx == 0) ? acc.wdata : ~acc.wdata;
        cpu_valid_i = 1'b1;
        cpu_be_i    = acc.be;
        cpu_addr_i  = acc.addr;
        cpu_we_i    = acc.we;
        cpu_wdata_i = wdata;
        waited      = 0;
        @(posedge clk_i);
        if (pass_idx == 0) begin
            // Response side never stalls in this pass
            assert (cpu_ready_o)
                else fail_now($sformatf("ERROR: time %0t cpu_ready_o = %0b, expected 1",
                                        $time, cpu_ready_o));
        end
        while (!cpu_ready_o) begin
            waited++;
            assert (waited < WAIT_LIMIT)
                else fail_now("Timeout waiting for cpu_ready_o to accept a request");
            @(posedge clk_i);
        end
        acc_edge_q.push_back(edge_cnt);
        exp_q.push_back(predict(acc, wdata));
        #1;
        cpu_valid_i = 1'b0;
    endtask

    task automatic apply_table(input int pass_idx);
        int gaps [NUM_ROWS];
        for (int i = 0; i < NUM_ROWS; i++) begin
            gaps[i] = (pass_idx != 0) ? int'($urandom_range(0, 2)) : 0;   // Idle cycles
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (gaps[i] > 0) begin
                repeat (gaps[i]) @(posedge clk_i);
                #1;
            end
            send_request(acc_table[i], pass_idx);
        end
    endtask

    task automatic collect_responses(input int pass_idx);
        int          got;
        int          waited;
        int          acc_edge;
        logic [7:0] exp_data;
        got    = 0;
        waited = 0;
        while (got < NUM_ROWS) begin
            @(posedge clk_i);
            waited++;
            assert (waited < RSP_LIMIT) else fail_now("Timeout waiting for responses");
            if (rsp_valid_o && rsp_ready_i) begin
                assert (exp_q.size() > 0)
                    else fail_now("Response arrived with no request outstanding");
                exp_data = exp_q.pop_front();
                acc_edge = acc_edge_q.pop_front();
                assert (rsp_data_o == exp_data)
                    else fail_now($sformatf("ERROR: time %0t rsp_data_o = %02h, expected %02h",
                                            $time, rsp_data_o, exp_data));
                if (pass_idx == 0) begin
                    assert (edge_cnt - acc_edge == 2)
                        else fail_now($sformatf("ERROR: time %0t latency = %0d, expected 2",
                                                $time, edge_cnt - acc_edge));
                end
                got++;
            end
            #1;
            rsp_ready_i = (pass_idx == 0) ? 1'b1 : ($urandom_range(0, 3) != 0);
        end
    endtask

    initial begin
        void'($urandom(32'habac06f2));
        clk_i       = 1'b0;
        arst_n_i    = 1'b0;
        cpu_valid_i = 1'b0;
        cpu_be_i    = 1'b0;
        cpu_addr_i  = '0;
        cpu_we_i    = 1'b0;
        cpu_wdata_i = '0;
        rsp_ready_i = 1'b1;
        for (int i = 0; i < 2 ** `CPU_ADDR_WIDTH; i++) begin
            ref_mem[i] = '0;
        end
        for (int b = 0; b < `NUM_IO_BANKS; b++) begin
            for (int r = 0; r < 2 ** `IO_REG_ADDR_BITS; r++) begin
                ref_regs[b][r] = '0;
            end
        end
        repeat (3) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        // Pass 0 checks fixed latency and pass 1 adds random back-pressure
        for (int pass_idx = 0; pass_idx < 2; pass_idx++) begin
            fork
                apply_table(pass_idx);
                collect_responses(pass_idx);
            join
        end
        repeat (4) begin
            @(posedge clk_i);
            assert (!rsp_valid_o) else fail_now("Extra response after all requests answered");
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: verif/pet_bus_props.sv
`timescale 1ns/1ps
`include "pet_bus_defs.svh"

module pet_bus_props (
    input logic                       clk_i,
    input logic                       arst_n_i,
    input logic                       rsp_valid_i,
    input logic                       rsp_ready_i,
    input logic [`CPU_DATA_WIDTH-1:0] rsp_data_i
);
    // A stalled response keeps both valid and data
    property p_stall_stable;
        @(posedge clk_i) disable iff (!arst_n_i)
        (rsp_valid_i && !rsp_ready_i) |=> (rsp_valid_i && $stable(rsp_data_i));
    endproperty

    a_stall_stable: assert property (p_stall_stable)
        else $error("Response valid or data changed while stalled");

    // Nothing pending right after a reset cycle
    a_reset_idle: assert property (@(posedge clk_i) !arst_n_i |=> !rsp_valid_i)
        else $error("Response valid seen after reset");

endmodule

bind read_data_mux pet_bus_props u_pet_bus_props (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .rsp_valid_i (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_data_i  (rsp_data_o)
);

// File: verilog/pet_bus_top.sv
`timescale 1ns/1ps
`include "pet_bus_defs.svh"

module pet_bus_top
    import pet_bus_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       arst_n_i,

    // CPU request
    input  logic                       cpu_valid_i,
    output logic                       cpu_ready_o,
    input  logic                       cpu_be_i,
    input  logic [`CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic                       cpu_we_i,
    input  logic [`CPU_DATA_WIDTH-1:0] cpu_wdata_i,

    // Response
    output logic                       rsp_valid_o,
    input  logic                       rsp_ready_i,
    output logic [`CPU_DATA_WIDTH-1:0] rsp_data_o
);
    logic [`CPU_DATA_WIDTH-1:0] ram_rdata;
    logic [`CPU_DATA_WIDTH-1:0] io_rdata [`NUM_IO_BANKS];

    cpu_bus_if bus ();

    address_decoding u_address_decoding (
        .cpu_be_i    (cpu_be_i),
        .cpu_valid_i (cpu_valid_i),
        .ready_i     (cpu_ready_o),
        .addr_i      (cpu_addr_i),
        .we_i        (cpu_we_i),
        .wdata_i     (cpu_wdata_i),
        .bus_o       (bus.source)
    );

    // Main RAM, VRAM and ROM share one array
    ram_port u_ram_port (
        .clk_i   (clk_i),
        .bus_i   (bus.target),
        .rdata_o (ram_rdata)
    );

    for (genvar b = 0; b < `NUM_IO_BANKS; b++) begin : g_io_bank
        io_register_bank #(
            .BANK (io_bank_e'(b))
        ) u_io_register_bank (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .bus_i    (bus.target),
            .rdata_o  (io_rdata[b])
        );
    end

    read_data_mux u_read_data_mux (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .bus_i       (bus.monitor),
        .ram_rdata_i (ram_rdata),
        .io_rdata_i  (io_rdata),
        .rsp_ready_i (rsp_ready_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_data_o  (rsp_data_o),
        .ready_o     (cpu_ready_o)                      // Back-pressure to the CPU
    );

endmodule

// File: verilog/read_data_mux.sv
`timescale 1ns/1ps
`include "pet_bus_defs.svh"

module read_data_mux
    import pet_bus_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    cpu_bus_if.monitor                 bus_i,
    input  logic [`CPU_DATA_WIDTH-1:0] ram_rdata_i,
    input  logic [`CPU_DATA_WIDTH-1:0] io_rdata_i [`NUM_IO_BANKS],
    input  logic                       rsp_ready_i,
    output logic                       rsp_valid_o,
    output logic [`CPU_DATA_WIDTH-1:0] rsp_data_o,
    output logic                       ready_o
);
    logic                       advance;
    logic                       s1_valid_q;
    logic                       s1_we_q;
    select_u                    s1_sel_q;
    logic [`CPU_DATA_WIDTH-1:0] s1_data;
    logic                       rsp_valid_q;
    logic [`CPU_DATA_WIDTH-1:0] rsp_data_q;

    // Response register empty or drained this cycle
    assign advance = !rsp_valid_q || rsp_ready_i;
    assign ready_o = advance;

    always_comb begin
        s1_data = '1;                                   // Open bus on empty select
        if (s1_sel_q.flags.ram_en) begin
            s1_data = ram_rdata_i;
        end
        for (int b = 0; b < `NUM_IO_BANKS; b++) begin
            if (s1_sel_q.raw[SEL_IO_LSB + b]) begin
                s1_data = io_rdata_i[b];
            end
        end
        if (s1_we_q) begin
            s1_data = '0;                               // Write acknowledge
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_valid_q  <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else if (advance) begin
            s1_valid_q  <= bus_i.fire;
            rsp_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus_i.fire) begin
            s1_we_q  <= bus_i.we;
            s1_sel_q <= bus_i.sel;
        end
        if (advance && s1_valid_q) begin
            rsp_data_q <= s1_data;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_data_o  = rsp_data_q;

endmodule

// File: verilog/ram_port.sv
`timescale 1ns/1ps
`include "pet_bus_defs.svh"

module ram_port (
    input  logic                       clk_i,
    cpu_bus_if.target                  bus_i,
    output logic [`CPU_DATA_WIDTH-1:0] rdata_o
);
    localparam int unsigned DEPTH = 2 ** `CPU_ADDR_WIDTH;

    logic [`CPU_DATA_WIDTH-1:0] mem [DEPTH];
    logic [`CPU_DATA_WIDTH-1:0] rdata_q;
    logic                       ram_hit;
    logic                       wr_en;

    // Power-up contents, no ROM image is loaded
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    assign ram_hit = bus_i.fire && bus_i.sel.flags.ram_en;

    // ROM area shares the array but never takes a write
    assign wr_en   = ram_hit && bus_i.we && !bus_i.sel.flags.is_readonly;

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[bus_i.addr] <= bus_i.wdata;             // Addr folded for VRAM
        end
    end

    // Registered read, kept until the next RAM access
    always_ff @(posedge clk_i) begin
        if (ram_hit) begin
            rdata_q <= mem[bus_i.addr];
        end
    end

    assign rdata_o = rdata_q;

endmodule

// File: verilog/io_register_bank.sv
`timescale 1ns/1ps
`include "pet_bus_defs.svh"

module io_register_bank
    import pet_bus_pkg::*;
#(
    parameter io_bank_e BANK = IO_SID
) (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    cpu_bus_if.target                  bus_i,
    output logic [`CPU_DATA_WIDTH-1:0] rdata_o
);
    localparam int unsigned NUM_REGS = 2 ** `IO_REG_ADDR_BITS;

    logic [`CPU_DATA_WIDTH-1:0]  regs_q [NUM_REGS];
    logic [`CPU_DATA_WIDTH-1:0]  rdata_q;
    logic [`IO_REG_ADDR_BITS-1:0] reg_idx;
    logic                         bank_hit;

    // Whole window aliases onto the low address bits
    assign reg_idx  = bus_i.addr[`IO_REG_ADDR_BITS-1:0];
    assign bank_hit = bus_i.fire && bus_i.sel.flags.io_en[BANK];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (bank_hit && bus_i.we) begin
            regs_q[reg_idx] <= bus_i.wdata;
        end
    end

    // Held while the response stage is stalled
    always_ff @(posedge clk_i) begin
        if (bank_hit) begin
            rdata_q <= regs_q[reg_idx];                 // Old value on a write
        end
    end

    assign rdata_o = rdata_q;

endmodule

// File: verilog/address_decoding.sv
`timescale 1ns/1ps
`include "pet_bus_defs.svh"

module address_decoding
    import pet_bus_pkg::*;
(
    input  logic                       cpu_be_i,
    input  logic                       cpu_valid_i,
    input  logic                       ready_i,
    input  logic [`CPU_ADDR_WIDTH-1:0] addr_i,
    input  logic                       we_i,
    input  logic [`CPU_DATA_WIDTH-1:0] wdata_i,
    cpu_bus_if.source                  bus_o
);
    localparam int unsigned AW          = `CPU_ADDR_WIDTH;
    localparam int unsigned MIRROR_LSB  = 10;

    // Clears bits 11:10 so the 1 KB VRAM repeats four times
    localparam logic [AW-1:0] FOLD_MASK =
        ~(((AW'(1) << `VRAM_MIRROR_BITS) - AW'(1)) << MIRROR_LSB);

    localparam logic [SEL_WIDTH-1:0] RAM_EN_MASK   = SEL_WIDTH'(1) << SEL_RAM_EN_BIT;
    localparam logic [SEL_WIDTH-1:0] READONLY_MASK = SEL_WIDTH'(1) << SEL_READONLY_BIT;
    localparam logic [SEL_WIDTH-1:0] MIRRORED_MASK = SEL_WIDTH'(1) << SEL_MIRRORED_BIT;

    // Memory map table entries as raw select words
    localparam logic [SEL_WIDTH-1:0] NONE  = '0;
    localparam logic [SEL_WIDTH-1:0] RAM   = RAM_EN_MASK;
    localparam logic [SEL_WIDTH-1:0] VRAM  = RAM_EN_MASK | MIRRORED_MASK;
    localparam logic [SEL_WIDTH-1:0] ROM   = RAM_EN_MASK | READONLY_MASK;
    localparam logic [SEL_WIDTH-1:0] SID   =
        SEL_WIDTH'(1) << (SEL_IO_LSB + int'(IO_SID));
    localparam logic [SEL_WIDTH-1:0] MAGIC =
        SEL_WIDTH'(1) << (SEL_IO_LSB + int'(IO_MAGIC));
    localparam logic [SEL_WIDTH-1:0] PIA1  =
        SEL_WIDTH'(1) << (SEL_IO_LSB + int'(IO_PIA1));
    localparam logic [SEL_WIDTH-1:0] PIA2  =
        SEL_WIDTH'(1) << (SEL_IO_LSB + int'(IO_PIA2));
    localparam logic [SEL_WIDTH-1:0] VIA   =
        SEL_WIDTH'(1) << (SEL_IO_LSB + int'(IO_VIA));
    localparam logic [SEL_WIDTH-1:0] CRTC  =
        SEL_WIDTH'(1) << (SEL_IO_LSB + int'(IO_CRTC));

    select_u sel;

    always_comb begin
        if (!cpu_be_i) begin
            sel.raw = NONE;                                 // Bus not driven by CPU
        end else begin
            priority casez (addr_i)
                16'b0???_????_????_????: sel.raw = RAM;     // 0000-7FFF
                16'b1000_1111_????_????: sel.raw = SID;     // 8F00-8FFF, wins over VRAM
                16'b1000_????_????_????: sel.raw = VRAM;    // 8000-8FFF
                16'b1110_1000_0000_????: sel.raw = MAGIC;   // E800-E80F
                16'b1110_1000_0001_????: sel.raw = PIA1;    // E810-E81F
                16'b1110_1000_001?_????: sel.raw = PIA2;    // E820-E83F
                16'b1110_1000_01??_????: sel.raw = VIA;     // E840-E87F
                16'b1110_1000_1???_????: sel.raw = CRTC;    // E880-E8FF
                default:                 sel.raw = ROM;     // Everything else
            endcase
        end
    end

    assign bus_o.sel   = sel;
    assign bus_o.fire  = cpu_valid_i && ready_i;
    assign bus_o.we    = we_i;
    assign bus_o.wdata = wdata_i;
    assign bus_o.addr  = sel.flags.is_mirrored ? (addr_i & FOLD_MASK) : addr_i;

endmodule

// File: verilog/cpu_bus_if.sv
`timescale 1ns/1ps
`include "pet_bus_defs.svh"

interface cpu_bus_if
    import pet_bus_pkg::*;
();
    logic                       fire;    // Request accepted on this edge
    logic                       we;
    logic [`CPU_ADDR_WIDTH-1:0] addr;    // Already folded for VRAM mirrors
    logic [`CPU_DATA_WIDTH-1:0] wdata;
    select_u                    sel;     // Decoded target

    modport source (
        output fire,
        output we,
        output addr,
        output wdata,
        output sel
    );

    modport target (
        input fire,
        input we,
        input addr,
        input wdata,
        input sel
    );

    // Response stage only needs the select and direction
    modport monitor (
        input fire,
        input we,
        input sel
    );
endinterface

// File: verilog/pet_bus_pkg.sv
`include "pet_bus_defs.svh"

package pet_bus_pkg;

    // Peripheral bank index, also the bit order of io_en
    typedef enum logic [2:0] {
        IO_SID   = 3'd0,
        IO_MAGIC = 3'd1,
        IO_PIA1  = 3'd2,
        IO_PIA2  = 3'd3,
        IO_VIA   = 3'd4,
        IO_CRTC  = 3'd5
    } io_bank_e;

    // Bit positions of the flags in the raw select word
    localparam int unsigned SEL_MIRRORED_BIT = 0;
    localparam int unsigned SEL_READONLY_BIT = 1;
    localparam int unsigned SEL_RAM_EN_BIT   = 2;
    localparam int unsigned SEL_IO_LSB       = 3;     // io_en[0] sits here
    localparam int unsigned SEL_WIDTH        = `NUM_IO_BANKS + 3;

    typedef struct packed {
        logic [`NUM_IO_BANKS-1:0] io_en;           // One-hot bank enables
        logic                     ram_en;
        logic                     is_readonly;     // ROM area
        logic                     is_mirrored;     // VRAM area
    } select_flags_t;

    // Decoder writes raw, RAM port reads flags, mux indexes raw by bank
    typedef union packed {
        select_flags_t        flags;
        logic [SEL_WIDTH-1:0] raw;
    } select_u;

endpackage

// File: verilog/pet_bus_defs.svh
`ifndef PET_BUS_DEFS_SVH
`define PET_BUS_DEFS_SVH

// CPU address width, 64 KB space
`define CPU_ADDR_WIDTH 16

// CPU data bus width
`define CPU_DATA_WIDTH 8

// SID, MAGIC, PIA1, PIA2, VIA, CRTC
`define NUM_IO_BANKS 6

// Low address bits that pick a register inside a bank
`define IO_REG_ADDR_BITS 4

// VRAM address bits 11 and 10 are cleared on a mirrored access
`define VRAM_MIRROR_BITS 2

`endif
